// File: rtl/frontend_cfg_pkg.sv
`default_nettype none

package frontend_cfg_pkg;

  // fetch address and global history
  typedef logic [31:0] addr_t;
  typedef logic [7:0]  ght_t;

  // one fetch block per cycle
  localparam int BLOCK_BYTES = 16;

  localparam int TB_SETS   = 16; // sets of two slots
  localparam int RAS_DEPTH = 8;

  // first fetch after reset
  localparam addr_t RESET_IP = 32'h0000_1000;

endpackage

`default_nettype wire

// File: rtl/branch_pkg.sv
`default_nettype none

package branch_pkg;

  typedef logic [1:0] br_kind_t;

  localparam br_kind_t KIND_COND   = 2'd0;
  localparam br_kind_t KIND_UNCOND = 2'd1;
  localparam br_kind_t KIND_CALL   = 2'd2;
  localparam br_kind_t KIND_RET    = 2'd3;

  typedef logic [7:0]  pred_idx_t; // direction table index
  typedef logic [23:0] tb_tag_t;   // address bits 31..8

endpackage

`default_nettype wire

// File: rtl/fetch_ctrl.sv
`default_nettype none

module fetch_ctrl (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            upd_en,
  input  wire                            upd_mispred,
  input  wire frontend_cfg_pkg::addr_t   upd_target,
  input  wire frontend_cfg_pkg::ght_t    upd_ght,
  input  wire                            hit0,
  input  wire                            hit1,
  input  wire branch_pkg::br_kind_t      kind0,
  input  wire branch_pkg::br_kind_t      kind1,
  input  wire frontend_cfg_pkg::addr_t   target0,
  input  wire frontend_cfg_pkg::addr_t   target1,
  input  wire                            pred_taken0,
  input  wire                            pred_taken1,
  input  wire frontend_cfg_pkg::addr_t   ras_top,
  output frontend_cfg_pkg::addr_t        fetch_ip,
  output frontend_cfg_pkg::ght_t         fetch_ght,
  output logic                           fetch_taken,
  output logic                           fetch_slot,
  output logic                           ras_push,
  output frontend_cfg_pkg::addr_t        ras_push_addr,
  output logic                           ras_pop
);

  logic                    take0;
  logic                    take1;
  logic                    redirect;
  branch_pkg::br_kind_t    win_kind;
  frontend_cfg_pkg::addr_t win_target;
  frontend_cfg_pkg::addr_t seq_ip;

  // conditional slots need the predictor, the rest always go
  assign take0 = hit0 && (kind0 != branch_pkg::KIND_COND || pred_taken0);
  assign take1 = hit1 && (kind1 != branch_pkg::KIND_COND || pred_taken1);

  assign fetch_taken = take0 || take1;
  assign fetch_slot  = !take0 && take1; // slot 0 has priority

  assign win_kind   = take0 ? kind0 : kind1;
  assign win_target = (win_kind == branch_pkg::KIND_RET) ? ras_top :
                      take0 ? target0 : target1;

  assign seq_ip   = fetch_ip + frontend_cfg_pkg::addr_t'(frontend_cfg_pkg::BLOCK_BYTES);
  assign redirect = upd_en && upd_mispred;

  // wrong-path fetch on a redirect, leave the stack alone
  assign ras_push      = fetch_taken && !redirect && win_kind == branch_pkg::KIND_CALL;
  assign ras_pop       = fetch_taken && !redirect && win_kind == branch_pkg::KIND_RET;
  assign ras_push_addr = seq_ip;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_ip  <= frontend_cfg_pkg::RESET_IP;
      fetch_ght <= '0;
    end else if (redirect) begin
      fetch_ip  <= upd_target;
      fetch_ght <= upd_ght;
    end else if (fetch_taken) begin
      fetch_ip  <= win_target;
      fetch_ght <= {fetch_ght[$bits(fetch_ght)-2:0], 1'b1};
    end else begin
      fetch_ip <= seq_ip;
      if (hit0 || hit1) begin
        fetch_ght <= {fetch_ght[$bits(fetch_ght)-2:0], 1'b0}; // hit, not taken
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/target_buffer.sv
`default_nettype none

module target_buffer (
  input  wire                            clk,
  input  wire                            rst,
  input  wire frontend_cfg_pkg::addr_t   lookup_ip,
  input  wire                            upd_en,
  input  wire                            upd_slot,
  input  wire frontend_cfg_pkg::addr_t   upd_src,
  input  wire frontend_cfg_pkg::addr_t   upd_target,
  input  wire branch_pkg::br_kind_t      upd_kind,
  output logic                           hit0,
  output logic                           hit1,
  output branch_pkg::br_kind_t           kind0,
  output branch_pkg::br_kind_t           kind1,
  output frontend_cfg_pkg::addr_t        target0,
  output frontend_cfg_pkg::addr_t        target1
);

  logic [$clog2(frontend_cfg_pkg::TB_SETS)-1:0] lk_set;
  logic [$clog2(frontend_cfg_pkg::TB_SETS)-1:0] upd_set;
  branch_pkg::tb_tag_t                          lk_tag;

  logic [1:0]              valid_q  [frontend_cfg_pkg::TB_SETS];
  branch_pkg::tb_tag_t     tag_q    [frontend_cfg_pkg::TB_SETS][2];
  branch_pkg::br_kind_t    kind_q   [frontend_cfg_pkg::TB_SETS][2];
  frontend_cfg_pkg::addr_t target_q [frontend_cfg_pkg::TB_SETS][2];

  logic [1:0]              hit;
  branch_pkg::br_kind_t    kind   [2];
  frontend_cfg_pkg::addr_t target [2];

  assign lk_set  = lookup_ip[7:4];
  assign lk_tag  = lookup_ip[31:8];
  assign upd_set = upd_src[7:4];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < frontend_cfg_pkg::TB_SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (upd_en) begin
      valid_q[upd_set][upd_slot] <= 1'b1;
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (upd_en) begin
      tag_q[upd_set][upd_slot]    <= upd_src[31:8];
      kind_q[upd_set][upd_slot]   <= upd_kind;
      target_q[upd_set][upd_slot] <= upd_target;
    end
  end

  for (genvar w = 0; w < 2; w++) begin : g_slot
    assign hit[w]    = valid_q[lk_set][w] && tag_q[lk_set][w] == lk_tag;
    assign kind[w]   = kind_q[lk_set][w];
    assign target[w] = target_q[lk_set][w];
  end

  assign hit0    = hit[0];
  assign hit1    = hit[1];
  assign kind0   = kind[0];
  assign kind1   = kind[1];
  assign target0 = target[0];
  assign target1 = target[1];

endmodule

`default_nettype wire

// File: rtl/dir_predictor.sv
`default_nettype none

module dir_predictor (
  input  wire                            clk,
  input  wire                            rst,
  input  wire frontend_cfg_pkg::addr_t   lookup_ip,
  input  wire frontend_cfg_pkg::ght_t    ght,
  input  wire                            upd_en,
  input  wire                            upd_mispred,
  input  wire                            upd_slot,
  input  wire frontend_cfg_pkg::addr_t   upd_src,
  input  wire frontend_cfg_pkg::ght_t    upd_ght,
  output logic                           pred_taken0,
  output logic                           pred_taken1
);

  // one bit per slot, three tables A, B, C
  logic [1:0]            tab_q   [3][2**$bits(branch_pkg::pred_idx_t)];
  branch_pkg::pred_idx_t lk_idx  [3];
  branch_pkg::pred_idx_t upd_idx [3];
  logic [1:0]            lk_bits [3];
  logic [1:0]            pred;

  // less address, more history going from A to C
  function automatic branch_pkg::pred_idx_t tab_idx(input frontend_cfg_pkg::addr_t ip,
                                                    input frontend_cfg_pkg::ght_t h,
                                                    input int t);
    case (t)
      0:       tab_idx = {ip[9:4], h[1:0]};
      1:       tab_idx = {ip[7:4], h[3:0]};
      default: tab_idx = {ip[5:4], h[5:0]};
    endcase
  endfunction

  for (genvar t = 0; t < 3; t++) begin : g_tab
    assign lk_idx[t]  = tab_idx(lookup_ip, ght, t);
    assign upd_idx[t] = tab_idx(upd_src, upd_ght, t);
    assign lk_bits[t] = tab_q[t][lk_idx[t]];
  end

  assign pred        = lk_bits[0] ^ lk_bits[1] ^ lk_bits[2];
  assign pred_taken0 = pred[0];
  assign pred_taken1 = pred[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < 3; t++) begin
        for (int i = 0; i < 2**$bits(branch_pkg::pred_idx_t); i++) begin
          tab_q[t][i] <= '0;
        end
      end
    end else if (upd_en && upd_mispred) begin
      // flipping all three always flips the xor
      for (int t = 0; t < 3; t++) begin
        tab_q[t][upd_idx[t]][upd_slot] <= ~tab_q[t][upd_idx[t]][upd_slot];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/return_stack.sv
`default_nettype none

module return_stack (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            push,
  input  wire frontend_cfg_pkg::addr_t   push_addr,
  input  wire                            pop,
  output frontend_cfg_pkg::addr_t        top
);

  logic [$clog2(frontend_cfg_pkg::RAS_DEPTH)-1:0] ptr_q;   // next free entry
  logic [$clog2(frontend_cfg_pkg::RAS_DEPTH)-1:0] top_ptr;
  frontend_cfg_pkg::addr_t                        mem_q [frontend_cfg_pkg::RAS_DEPTH];

  assign top_ptr = ptr_q - 1'b1;
  assign top     = mem_q[top_ptr];

  // pointer wraps, so overflow lands on the oldest entry
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q <= '0;
    end else if (push) begin
      ptr_q <= ptr_q + 1'b1;
    end else if (pop) begin
      ptr_q <= top_ptr;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[ptr_q] <= push_addr;
    end
  end

endmodule

`default_nettype wire

// File: rtl/frontend_top.sv
`default_nettype none

module frontend_top (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            upd_en,
  input  wire                            upd_slot,
  input  wire frontend_cfg_pkg::addr_t   upd_src,
  input  wire frontend_cfg_pkg::addr_t   upd_target,
  input  wire branch_pkg::br_kind_t      upd_kind,
  input  wire frontend_cfg_pkg::ght_t    upd_ght,
  input  wire                            upd_mispred,
  output frontend_cfg_pkg::addr_t        fetch_ip,
  output frontend_cfg_pkg::ght_t         fetch_ght,
  output logic                           fetch_taken,
  output logic                           fetch_slot
);

  logic                    hit0;
  logic                    hit1;
  branch_pkg::br_kind_t    kind0;
  branch_pkg::br_kind_t    kind1;
  frontend_cfg_pkg::addr_t target0;
  frontend_cfg_pkg::addr_t target1;
  logic                    pred_taken0;
  logic                    pred_taken1;
  frontend_cfg_pkg::addr_t ras_top;
  logic                    ras_push;
  frontend_cfg_pkg::addr_t ras_push_addr;
  logic                    ras_pop;

  fetch_ctrl u_fetch_ctrl (
    .clk(clk), .rst(rst),
    .upd_en(upd_en), .upd_mispred(upd_mispred), .upd_target(upd_target), .upd_ght(upd_ght),
    .hit0(hit0), .hit1(hit1), .kind0(kind0), .kind1(kind1),
    .target0(target0), .target1(target1),
    .pred_taken0(pred_taken0), .pred_taken1(pred_taken1), .ras_top(ras_top),
    .fetch_ip(fetch_ip), .fetch_ght(fetch_ght),
    .fetch_taken(fetch_taken), .fetch_slot(fetch_slot),
    .ras_push(ras_push), .ras_push_addr(ras_push_addr), .ras_pop(ras_pop)
  );

  target_buffer u_target_buffer (
    .clk(clk), .rst(rst), .lookup_ip(fetch_ip),
    .upd_en(upd_en), .upd_slot(upd_slot), .upd_src(upd_src),
    .upd_target(upd_target), .upd_kind(upd_kind),
    .hit0(hit0), .hit1(hit1), .kind0(kind0), .kind1(kind1),
    .target0(target0), .target1(target1)
  );

  dir_predictor u_dir_predictor (
    .clk(clk), .rst(rst), .lookup_ip(fetch_ip), .ght(fetch_ght),
    .upd_en(upd_en), .upd_mispred(upd_mispred), .upd_slot(upd_slot),
    .upd_src(upd_src), .upd_ght(upd_ght),
    .pred_taken0(pred_taken0), .pred_taken1(pred_taken1)
  );

  return_stack u_return_stack (
    .clk(clk), .rst(rst),
    .push(ras_push), .push_addr(ras_push_addr), .pop(ras_pop),
    .top(ras_top)
  );

endmodule

`default_nettype wire

// File: bench/frontend_checker.sv
`default_nettype none

module frontend_checker (
  input wire                          clk,
  input wire                          rst,
  input wire                          upd_en,
  input wire                          upd_slot,
  input wire frontend_cfg_pkg::addr_t upd_src,
  input wire frontend_cfg_pkg::addr_t upd_target,
  input wire branch_pkg::br_kind_t    upd_kind,
  input wire frontend_cfg_pkg::ght_t  upd_ght,
  input wire                          upd_mispred,
  input wire frontend_cfg_pkg::addr_t fetch_ip,
  input wire frontend_cfg_pkg::ght_t  fetch_ght,
  input wire                          fetch_taken,
  input wire                          fetch_slot
);

  frontend_cfg_pkg::addr_t m_ip;
  frontend_cfg_pkg::ght_t  m_ght;
  logic [1:0]              vld [16];
  frontend_cfg_pkg::addr_t src_q [16][2]; // full source, tag is 31..8
  branch_pkg::br_kind_t    kd_q [16][2];
  frontend_cfg_pkg::addr_t tgt_q [16][2];
  logic [1:0]              tab [3][256];
  frontend_cfg_pkg::addr_t ras [8];
  logic [2:0]              sp;
  string                   cur_name;
  bit                      bad;
  int                      n_pass;
  int                      n_fail;

  initial begin
    n_pass = 0;
    n_fail = 0;
    bad = 0;
  end

  function automatic branch_pkg::pred_idx_t pidx(input int t, input frontend_cfg_pkg::addr_t ip,
                                                 input frontend_cfg_pkg::ght_t h);
    if (t == 0) return {ip[9:4], h[1:0]};
    if (t == 1) return {ip[7:4], h[3:0]};
    return {ip[5:4], h[5:0]};
  endfunction

  // slot 0 is visited last so it wins
  task automatic predict(output bit tk, output bit sl, output bit hit_any);
    logic [3:0] set;
    bit         hit;
    bit         p;
    set = m_ip[7:4];
    tk = 0;
    sl = 0;
    hit_any = 0;
    for (int s = 1; s >= 0; s--) begin
      hit = vld[set][s] && src_q[set][s][31:8] == m_ip[31:8];
      p = tab[0][pidx(0, m_ip, m_ght)][s] ^ tab[1][pidx(1, m_ip, m_ght)][s]
          ^ tab[2][pidx(2, m_ip, m_ght)][s];
      hit_any = hit_any | hit;
      if (hit && (kd_q[set][s] != branch_pkg::KIND_COND || p)) begin
        tk = 1;
        sl = (s == 1);
      end
    end
  endtask

  always @(posedge clk) begin : model
    bit                      tk;
    bit                      sl;
    bit                      hit_any;
    frontend_cfg_pkg::addr_t nip;
    frontend_cfg_pkg::ght_t  nght;
    branch_pkg::br_kind_t    k;
    if (rst) begin
      m_ip = frontend_cfg_pkg::RESET_IP;
      m_ght = '0;
      sp = '0;
      for (int s = 0; s < 16; s++) vld[s] = '0;
      for (int i = 0; i < 256; i++) begin
        tab[0][i] = '0;
        tab[1][i] = '0;
        tab[2][i] = '0;
      end
    end else begin
      predict(tk, sl, hit_any);
      nght = m_ght;
      if (upd_en && upd_mispred) begin
        nip = upd_target;
        nght = upd_ght;
      end else if (tk) begin
        k = kd_q[m_ip[7:4]][sl];
        nip = (k == branch_pkg::KIND_RET) ? ras[sp - 3'd1] : tgt_q[m_ip[7:4]][sl];
        if (k == branch_pkg::KIND_CALL) begin
          ras[sp] = m_ip + 32'd16; // return lands on the next block
          sp = sp + 3'd1;
        end
        if (k == branch_pkg::KIND_RET) sp = sp - 3'd1;
        nght = {m_ght[6:0], 1'b1};
      end else begin
        nip = m_ip + 32'd16;
        if (hit_any) nght = {m_ght[6:0], 1'b0};
      end
      if (upd_en) begin
        vld[upd_src[7:4]][upd_slot] = 1'b1;
        src_q[upd_src[7:4]][upd_slot] = upd_src;
        kd_q[upd_src[7:4]][upd_slot] = upd_kind;
        tgt_q[upd_src[7:4]][upd_slot] = upd_target;
        if (upd_mispred) begin
          for (int t = 0; t < 3; t++) begin
            tab[t][pidx(t, upd_src, upd_ght)][upd_slot] ^= 1'b1;
          end
        end
      end
      m_ip = nip;
      m_ght = nght;
    end
  end

  task automatic check(input string what, input logic [31:0] e, input logic [31:0] a);
    if (e !== a) begin
      if (!bad) $display("ERR %s %s expected %h actual %h", cur_name, what, e, a);
      bad = 1;
    end
  endtask

  task automatic compare();
    bit tk;
    bit sl;
    bit h;
    predict(tk, sl, h);
    check("fetch_ip", m_ip, fetch_ip);
    check("fetch_ght", 32'(m_ght), 32'(fetch_ght));
    check("fetch_taken", 32'(tk), 32'(fetch_taken));
    if (tk) check("fetch_slot", 32'(sl), 32'(fetch_slot));
  endtask

  always @(negedge clk) begin
    if (!rst) compare();
  end

  task automatic start_test(input string name);
    cur_name = name;
    bad = 0;
  endtask

  task automatic end_test(input frontend_cfg_pkg::addr_t expect_ip);
    compare();
    check("final fetch_ip", expect_ip, fetch_ip);
    if (bad) begin
      n_fail++;
      $display("FAIL %s", cur_name);
    end else begin
      n_pass++;
      $display("PASS %s", cur_name);
    end
  endtask

endmodule

`default_nettype wire

// File: bench/tb_frontend.sv
`default_nettype none

module tb_frontend;

  logic                    clk;
  logic                    rst;
  logic                    upd_en;
  logic                    upd_slot;
  frontend_cfg_pkg::addr_t upd_src;
  frontend_cfg_pkg::addr_t upd_target;
  branch_pkg::br_kind_t    upd_kind;
  frontend_cfg_pkg::ght_t  upd_ght;
  logic                    upd_mispred;
  frontend_cfg_pkg::addr_t fetch_ip;
  frontend_cfg_pkg::ght_t  fetch_ght;
  logic                    fetch_taken;
  logic                    fetch_slot;

  // one entry per vector line
  string names [32];
  int    v_rst [32];
  int    v_ucyc [32];
  int    v_slot [32];
  int    v_kind [32];
  int    v_misp [32];
  int    v_cycles [32];
  logic [31:0] v_src [32];
  logic [31:0] v_tgt [32];
  logic [31:0] v_ght [32];
  logic [31:0] v_exp [32];
  int    n_tests;
  int    limit;
  bit    loaded;

  frontend_top DUT (
    .clk(clk), .rst(rst), .upd_en(upd_en), .upd_slot(upd_slot), .upd_src(upd_src),
    .upd_target(upd_target), .upd_kind(upd_kind), .upd_ght(upd_ght),
    .upd_mispred(upd_mispred), .fetch_ip(fetch_ip), .fetch_ght(fetch_ght),
    .fetch_taken(fetch_taken), .fetch_slot(fetch_slot)
  );

  frontend_checker chk (
    .clk(clk), .rst(rst), .upd_en(upd_en), .upd_slot(upd_slot), .upd_src(upd_src),
    .upd_target(upd_target), .upd_kind(upd_kind), .upd_ght(upd_ght),
    .upd_mispred(upd_mispred), .fetch_ip(fetch_ip), .fetch_ght(fetch_ght),
    .fetch_taken(fetch_taken), .fetch_slot(fetch_slot)
  );

  initial begin
    clk = 0;
    forever #5 clk = ~clk;
  end

  initial begin
    wait (loaded);
    #(limit);
    $display("timeout: the tests did not finish within %0d time units", limit);
    $display("sim failed");
    $finish;
  end

  task automatic load_vectors();
    int    fd;
    int    cnt;
    string line;
    n_tests = 0;
    fd = $fopen("bench/frontend_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file");
    end else begin
      while (!$feof(fd) && n_tests < 32) begin
        cnt = $fgets(line, fd);
        if (cnt < 2 || line.substr(0, 0) == "#") continue;
        cnt = $sscanf(line, "%s %d %d %d %h %h %d %h %d %d %h", names[n_tests],
                      v_rst[n_tests], v_ucyc[n_tests], v_slot[n_tests], v_src[n_tests],
                      v_tgt[n_tests], v_kind[n_tests], v_ght[n_tests], v_misp[n_tests],
                      v_cycles[n_tests], v_exp[n_tests]);
        if (cnt == 11) n_tests++;
      end
      $fclose(fd);
    end
  endtask

  // called 1 unit after a rising edge
  task automatic run_test(input int t);
    chk.start_test(names[t]);
    if (v_rst[t] != 0) begin
      rst = 1;
      repeat (4) @(posedge clk);
      #1 rst = 0;
    end
    for (int i = 0; i < v_cycles[t]; i++) begin
      upd_en = (i == v_ucyc[t]);
      upd_slot = v_slot[t][0];
      upd_src = v_src[t];
      upd_target = v_tgt[t];
      upd_kind = v_kind[t][1:0];
      upd_ght = v_ght[t][7:0];
      upd_mispred = v_misp[t][0];
      @(posedge clk);
      #1;
    end
    upd_en = 0;
    chk.end_test(v_exp[t]);
  endtask

  initial begin
    rst = 1;
    upd_en = 0;
    upd_slot = 0;
    upd_src = '0;
    upd_target = '0;
    upd_kind = '0;
    upd_ght = '0;
    upd_mispred = 0;
    loaded = 0;
    load_vectors();
    limit = 200;
    for (int t = 0; t < n_tests; t++) begin
      limit += (v_cycles[t] + (v_rst[t] != 0 ? 4 : 0) + 1) * 10;
    end
    loaded = 1;
    for (int t = 0; t < n_tests; t++) run_test(t);
    $display("tests passed %0d failed %0d", chk.n_pass, chk.n_fail);
    if (chk.n_fail == 0 && n_tests > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
rtl/frontend_cfg_pkg.sv
rtl/branch_pkg.sv
rtl/fetch_ctrl.sv
rtl/target_buffer.sv
rtl/dir_predictor.sv
rtl/return_stack.sv
rtl/frontend_top.sv
bench/frontend_checker.sv
bench/tb_frontend.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the fetch front-end testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_frontend -f all.f -o sim_frontend
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_frontend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" sim.log; then
  exit 0
fi
exit 1

// File: bench/frontend_vectors.txt
# name reset upd_cycle upd_slot upd_src upd_target upd_kind upd_ght upd_mispred cycles expect_ip
# upd_cycle -1 means no update; kind 0 cond, 1 jump, 2 call, 3 return; hex for addresses and ght
seq        1 -1 0 00000000 00000000 0 00 0 8  00001080
jump       1  0 0 00001040 00002000 1 00 0 10 00002050
cond_nt    1  0 0 00001020 00003000 0 00 0 6  00001060
cond_t     0  0 0 00001020 00001000 0 00 1 5  00001010
ret_inst   1  0 0 00004020 00000000 3 00 0 1  00001010
call_ret   0  0 1 00001020 00004000 2 00 0 5  00001030
redirect   1  3 0 00005000 00006000 1 a5 1 4  00006000
slot1_inst 1  0 1 00001030 00007100 1 00 0 1  00001010
both_slots 0  0 0 00001030 00007000 1 00 0 3  00007000
